// File: compile.f
source/pn_mon_pkg.sv
source/adc_sample_format.sv
source/pn_sync_track.sv
source/pn_chan_check.sv
source/pn_status_regs.sv
source/adc_pn_check_top.sv
verification/pn_clk_gen.sv
verification/adc_pn_check_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the PN monitor testbench with Verilator and run it
# exit status is nonzero when the build, the run or a check fails

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module adc_pn_check_tb -f compile.f -o adc_pn_check_sim \
  && ./obj_dir/adc_pn_check_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// File: source/adc_pn_check_top.sv
// top level of the ADC PN test-pattern monitor
// input beat -> format stage -> one checker per channel -> status
// status shows the effect of a beat three cycles after it is accepted

`timescale 1ns/100ps

module adc_pn_check_top (
  input  logic                                           clk,
  input  logic                                           rst,
  input  pn_mon_pkg::adc_beat_t                          beat,
  input  logic                                           valid,
  input  pn_mon_pkg::pn_cfg_t                            cfg,
  input  logic                                           status_clear,
  output pn_mon_pkg::pn_status_t [pn_mon_pkg::num_chan-1:0] status
);

  import pn_mon_pkg::*;

  // formatted beat shared by all checkers
  adc_beat_t fmt_beat;
  logic      fmt_valid;

  // checker results towards the status block
  logic [num_chan-1:0] chan_oos;
  logic [num_chan-1:0] chan_err;

  genvar c;

  adc_sample_format u_format (
    .clk           (clk),
    .rst           (rst),
    .beat_in       (beat),
    .valid         (valid),
    .offset_binary (cfg.offset_binary),
    .fmt_beat      (fmt_beat),
    .fmt_valid     (fmt_valid)
  );

  // ********************
  // channel checkers
  // ********************

  generate
    for (c = 0; c < num_chan; c++) begin : g_chk
      pn_chan_check u_check (
        .clk      (clk),
        .rst      (rst),
        .rx       (fmt_beat.ch[c]),
        .rx_valid (fmt_valid),
        .seq_sel  (cfg.seq_sel[c]),
        .oos      (chan_oos[c]),
        .err      (chan_err[c])
      );
    end
  endgenerate

  pn_status_regs u_status (
    .clk    (clk),
    .rst    (rst),
    .oos    (chan_oos),
    .err    (chan_err),
    .clear  (status_clear),
    .status (status)
  );

endmodule

// File: source/adc_sample_format.sv
// input stage of the PN monitor
// converts offset-binary samples to two's complement when asked,
// puts the oldest sample in the most significant slot of each
// channel word and registers the beat together with its strobe

`timescale 1ns/100ps

module adc_sample_format (
  input  logic                  clk,
  input  logic                  rst,
  input  pn_mon_pkg::adc_beat_t beat_in,
  input  logic                  valid,
  input  logic                  offset_binary,
  output pn_mon_pkg::adc_beat_t fmt_beat,
  output logic                  fmt_valid
);

  import pn_mon_pkg::*;

  // combinational result before the register stage
  adc_beat_t fmt_next;

  genvar k;

  // ********************
  // sign and order
  // ********************

  always_comb begin
    fmt_next = beat_in;
    for (int c = 0; c < num_chan; c++) begin
      for (int s = 0; s < samples_per_beat; s++) begin
        // sample 0 arrives first, so it lands in the top slot
        fmt_next.ch[c].sample[samples_per_beat-1-s] = beat_in.ch[c].sample[s];
        // offset binary differs from two's complement only in the msb
        fmt_next.ch[c].sample[samples_per_beat-1-s][chan_width-1] =
          beat_in.ch[c].sample[s][chan_width-1] ^ offset_binary;
      end
    end
  end

  // ********************
  // register stage
  // ********************

  // formatted beat register
  always_ff @(posedge clk) begin
    fmt_beat <= fmt_next;
  end

  // strobe follows the data through exactly one flop
  always_ff @(posedge clk) begin
    if (rst) begin
      fmt_valid <= 1'b0;
    end else begin
      fmt_valid <= valid;
    end
  end

  // ********************
  // checks
  // ********************

  generate
    for (k = 0; k < num_chan; k++) begin : g_chk
      // seen as a flat word each channel has its halves swapped and, in
      // offset-binary mode, both sample msbs flipped, one cycle later
      assert property (@(posedge clk) disable iff (rst)
        valid |=> fmt_valid && (fmt_beat.ch[k].raw ==
          ({$past(beat_in.ch[k].raw[chan_width-1:0]),
            $past(beat_in.ch[k].raw[beat_width-1:chan_width])} ^
           {$past(offset_binary), {(chan_width-1){1'b0}},
            $past(offset_binary), {(chan_width-1){1'b0}}})))
        else $error("formatted beat does not follow valid beat on channel %0d", k);
    end
  endgenerate

endmodule

// File: source/pn_chan_check.sv
// per-channel PN checker
// predicts the next 32 bits of the selected PN9 or PN23 sequence and
// hands the prediction to the lock tracker together with the received
// word. while out of sync the prediction is rebuilt from received data
// so the checker can pick up a stream at any point

`timescale 1ns/100ps

module pn_chan_check (
  input  logic                   clk,
  input  logic                   rst,
  input  pn_mon_pkg::chan_beat_u rx,
  input  logic                   rx_valid,
  input  pn_mon_pkg::pn_seq_e    seq_sel,
  output logic                   oos,
  output logic                   err
);

  import pn_mon_pkg::*;

  // seed for the next prediction
  logic [beat_width-1:0] pn_seed;
  // 32 lfsr steps ahead of the seed
  logic [beat_width-1:0] pn_step;
  // expected word for the beat now on rx
  logic [beat_width-1:0] pn_pred;

  // ********************
  // parallel lfsr
  // ********************

  // runs the polynomial over a whole beat
  // the seed sits on top, new bits are filled in from msb to lsb
  function automatic logic [beat_width-1:0] pn_advance(
    input logic [beat_width-1:0] seed,
    input pn_seq_e               sel
  );
    logic [2*beat_width-1:0] full;
    int i;
    full = {seed, {beat_width{1'b0}}};
    for (i = beat_width - 1; i >= 0; i--) begin
      if (sel == pn9) begin
        full[i] = full[i+pn9_len] ^ full[i+pn9_tap];
      end else begin
        full[i] = full[i+pn23_len] ^ full[i+pn23_tap];
      end
    end
    return full[beat_width-1:0];
  endfunction

  // out of sync: trust the wire, in sync: trust our own sequence
  assign pn_seed = oos ? rx.raw : pn_pred;
  assign pn_step = pn_advance(pn_seed, seq_sel);

  // ********************
  // prediction register
  // ********************

  // advance only on real beats so idle cycles leave the sequence alone
  always_ff @(posedge clk) begin
    if (rst) begin
      pn_pred <= '0;
    end else if (rx_valid) begin
      pn_pred <= pn_step;
    end
  end

  // ********************
  // lock tracking
  // ********************

  // rx and pn_pred line up here, both belong to the current beat
  pn_sync_track u_sync (
    .clk     (clk),
    .rst     (rst),
    .rx_data (rx.raw),
    .pn_data (pn_pred),
    .valid   (rx_valid),
    .oos     (oos),
    .err     (err)
  );

  // a locked checker runs on a nonzero lfsr state, all zero would be stuck
  assert property (@(posedge clk) disable iff (rst)
    !oos |-> (pn_pred != '0))
    else $error("prediction is all zero while in sync");

endmodule

// File: source/pn_mon_pkg.sv
// shared sizes and types for the ADC PN test-pattern monitor
// one beat carries samples_per_beat samples for each of num_chan channels
// modules import this package inside their bodies and use scoped
// names in their port lists

package pn_mon_pkg;

  // ********************
  // link sizes
  // ********************

  // bits per converter sample
  localparam int chan_width = 16;
  // samples per channel per beat
  localparam int samples_per_beat = 2;
  // converter channels
  localparam int num_chan = 2;
  // flat channel word per beat
  localparam int beat_width = chan_width * samples_per_beat;

  // ********************
  // lock and error sizes
  // ********************

  // run length to gain and to lose sync
  localparam int lock_count = 16;
  // run counter only needs to reach lock_count - 1
  localparam int lock_cnt_width = $clog2(lock_count);
  // saturating error counter width
  localparam int err_count_width = 16;

  // ********************
  // pn polynomials
  // ********************

  // PN9 is x^9 + x^5 + 1
  localparam int pn9_len = 9;
  localparam int pn9_tap = 5;
  // PN23 is x^23 + x^18 + 1
  localparam int pn23_len = 23;
  localparam int pn23_tap = 18;

  // pattern select per channel
  typedef enum logic {
    pn9  = 1'b0,
    pn23 = 1'b1
  } pn_seq_e;

  // ********************
  // beat and status types
  // ********************

  // one channel beat, either as a flat word or split into samples
  // raw has the earliest pn bit in the msb
  typedef union packed {
    logic [beat_width-1:0] raw;
    logic [samples_per_beat-1:0][chan_width-1:0] sample;
  } chan_beat_u;

  // full converter beat, channel 0 in the low bits
  typedef struct packed {
    chan_beat_u [num_chan-1:0] ch;
  } adc_beat_t;

  // quasi-static configuration
  typedef struct packed {
    logic offset_binary;
    pn_seq_e [num_chan-1:0] seq_sel;
  } pn_cfg_t;

  // per-channel status word
  typedef struct packed {
    logic oos;
    logic err_sticky;
    logic [err_count_width-1:0] err_count;
  } pn_status_t;

endpackage

// File: source/pn_status_regs.sv
// output status for all PN channels
// mirrors each oos level and collects errors into a sticky flag and a
// saturating counter. clear empties flags and counters but leaves oos,
// and it wins over an error arriving in the same cycle

`timescale 1ns/100ps

module pn_status_regs (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic [pn_mon_pkg::num_chan-1:0]                oos,
  input  logic [pn_mon_pkg::num_chan-1:0]                err,
  input  logic                                           clear,
  output pn_mon_pkg::pn_status_t [pn_mon_pkg::num_chan-1:0] status
);

  import pn_mon_pkg::*;

  genvar c;

  // ********************
  // per channel status
  // ********************

  generate
    for (c = 0; c < num_chan; c++) begin : g_chan

      // counter stops at all ones
      logic cnt_full;
      assign cnt_full = &status[c].err_count;

      always_ff @(posedge clk) begin
        if (rst) begin
          // checker starts out of sync
          status[c].oos        <= 1'b1;
          status[c].err_sticky <= 1'b0;
          status[c].err_count  <= '0;
        end else begin
          status[c].oos <= oos[c];
          if (clear) begin
            status[c].err_sticky <= 1'b0;
            status[c].err_count  <= '0;
          end else if (err[c]) begin
            status[c].err_sticky <= 1'b1;
            if (!cnt_full) begin
              status[c].err_count <= status[c].err_count + 1'b1;
            end
          end
        end
      end

      // once full the count only leaves all ones through clear
      assert property (@(posedge clk) disable iff (rst)
        cnt_full |=> (status[c].err_count != '0) || $past(clear))
        else $error("err_count wrapped on channel %0d", c);

    end
  endgenerate

endmodule

// File: source/pn_sync_track.sv
// lock tracker for one PN channel
// judges each valid beat against the prediction and keeps a run
// counter for the hysteresis. lock_count matching beats clear oos,
// lock_count mismatching beats set it again. while in sync every
// mismatch gives a one-cycle err pulse

`timescale 1ns/100ps

module pn_sync_track (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [pn_mon_pkg::beat_width-1:0] rx_data,
  input  logic [pn_mon_pkg::beat_width-1:0] pn_data,
  input  logic                              valid,
  output logic                              oos,
  output logic                              err
);

  import pn_mon_pkg::*;

  // beat judged good
  logic match;
  // run of beats that point away from the current state
  logic [lock_cnt_width-1:0] run_cnt;
  // this beat would move oos if the run completes
  logic run_hit;

  // an all zero word also matches a dead lfsr, so never accept it
  assign match = (rx_data == pn_data) && (rx_data != '0);

  // out of sync counts matches, in sync counts mismatches
  assign run_hit = oos ? match : !match;

  // ********************
  // hysteresis
  // ********************

  always_ff @(posedge clk) begin
    if (rst) begin
      oos     <= 1'b1;
      run_cnt <= '0;
    end else if (valid) begin
      if (!run_hit) begin
        // run broken, start over
        run_cnt <= '0;
      end else if (run_cnt == lock_cnt_width'(lock_count - 1)) begin
        oos     <= !oos;
        run_cnt <= '0;
      end else begin
        run_cnt <= run_cnt + 1'b1;
      end
    end
  end

  // ********************
  // error pulse
  // ********************

  // also fires on the beat that drops the lock
  always_ff @(posedge clk) begin
    if (rst) begin
      err <= 1'b0;
    end else begin
      err <= valid && !oos && !match;
    end
  end

  // losing the lock always ends a run of mismatches judged in sync,
  // so the beat that sets oos must raise err as well
  assert property (@(posedge clk) disable iff (rst)
    $rose(oos) |-> err)
    else $error("oos set without an err pulse");

endmodule

// File: verification/adc_pn_check_tb.sv
// testbench for the ADC PN test-pattern monitor
// sends PN9 and PN23 streams through the top level, injects bit errors,
// zero runs, a clear, offset-binary data and idle garbage, and checks
// the status words against a beat-level model after every phase
// run it from the project root with the sh script there

`timescale 1ns/100ps

module adc_pn_check_tb;

  import pn_mon_pkg::*;

  // six phases of at most 200 beats each, plus margins
  localparam int timeout_cycles = 3000;

  logic clk;
  logic rst;
  adc_beat_t beat;
  logic valid;
  pn_cfg_t cfg;
  logic status_clear;
  pn_status_t [num_chan-1:0] status;

  // expected status and checker model per channel
  pn_status_t exp_status [num_chan];
  int run_len [num_chan];
  logic [beat_width-1:0] pred_word [num_chan];
  // last word sent by each transmitter
  logic [beat_width-1:0] tx_word [num_chan];

  int error_count;
  int cycle_count;
  integer seed;
  // phase end handshake with the compare process
  logic check_req;
  logic check_ack;

  pn_clk_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  adc_pn_check_top dut (
    .clk          (clk),
    .rst          (rst),
    .beat         (beat),
    .valid        (valid),
    .cfg          (cfg),
    .status_clear (status_clear),
    .status       (status)
  );

  // ********************
  // reference model
  // ********************

  // next 32 bits of the sequence, earliest bit ends up in the msb
  function automatic logic [beat_width-1:0] pn_next_beat(
    input logic [beat_width-1:0] prev,
    input pn_seq_e               sel
  );
    logic [beat_width-1:0] hist;
    logic nb;
    hist = prev;
    for (int n = 0; n < beat_width; n++) begin
      // hist[k] is the bit sent k+1 steps ago
      if (sel == pn9) begin
        nb = hist[8] ^ hist[4];
      end else begin
        nb = hist[22] ^ hist[17];
      end
      hist = {hist[beat_width-2:0], nb};
    end
    return hist;
  endfunction

  // undo the format stage: earliest sample in the low half, msb flipped
  // for offset binary
  function automatic adc_beat_t pack_beat(
    input logic [beat_width-1:0] raw0,
    input logic [beat_width-1:0] raw1,
    input logic                  ob
  );
    logic [beat_width-1:0] raw [num_chan];
    adc_beat_t b;
    raw[0] = raw0;
    raw[1] = raw1;
    for (int c = 0; c < num_chan; c++) begin
      b.ch[c].raw = {raw[c][chan_width-1:0], raw[c][beat_width-1:chan_width]};
      if (ob) begin
        b.ch[c].raw[chan_width-1] = ~b.ch[c].raw[chan_width-1];
        b.ch[c].raw[beat_width-1] = ~b.ch[c].raw[beat_width-1];
      end
    end
    return b;
  endfunction

  // one valid beat as the checker sees it
  task automatic model_beat(input int c, input logic [beat_width-1:0] rx);
    logic match;
    logic hit;
    match = (rx == pred_word[c]) && (rx != '0);
    if (!exp_status[c].oos && !match) begin
      exp_status[c].err_sticky = 1'b1;
      if (exp_status[c].err_count != '1) begin
        exp_status[c].err_count = exp_status[c].err_count + 1'b1;
      end
    end
    hit = exp_status[c].oos ? match : !match;
    // reseed from the wire while out of sync, judged with the old oos
    pred_word[c] = pn_next_beat(exp_status[c].oos ? rx : pred_word[c], cfg.seq_sel[c]);
    if (!hit) begin
      run_len[c] = 0;
    end else if (run_len[c] == lock_count - 1) begin
      exp_status[c].oos = !exp_status[c].oos;
      run_len[c] = 0;
    end else begin
      run_len[c] = run_len[c] + 1;
    end
  endtask

  // ********************
  // checks
  // ********************

  task automatic check_status(input string name, input pn_status_t exp, input pn_status_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_oos(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  // waits out the pipeline, then compares every channel
  initial begin : compare_proc
    check_ack = 1'b0;
    forever begin
      wait (check_req);
      repeat (5) @(posedge clk);
      #5;
      for (int c = 0; c < num_chan; c++) begin
        check_status($sformatf("status[%0d]", c), exp_status[c], status[c]);
      end
      check_ack = 1'b1;
      wait (!check_req);
      check_ack = 1'b0;
    end
  end

  // ********************
  // stimulus
  // ********************

  task automatic send_beat(input logic [beat_width-1:0] raw0, input logic [beat_width-1:0] raw1);
    @(posedge clk);
    #1;
    beat = pack_beat(raw0, raw1, cfg.offset_binary);
    valid = 1'b1;
    model_beat(0, raw0);
    model_beat(1, raw1);
  endtask

  // continues both streams, optional zero run on ch0 and bit errors on ch1
  task automatic send_stream(input int beats, input bit zero_ch0, input int err_gap);
    logic [beat_width-1:0] w [num_chan];
    int bit_idx;
    for (int n = 0; n < beats; n++) begin
      for (int c = 0; c < num_chan; c++) begin
        tx_word[c] = pn_next_beat(tx_word[c], cfg.seq_sel[c]);
        w[c] = tx_word[c];
      end
      if (zero_ch0) begin
        w[0] = '0;
      end
      if (err_gap > 0 && (n % err_gap) == err_gap - 1) begin
        bit_idx = $unsigned($random(seed)) % beat_width;
        w[1][bit_idx] = ~w[1][bit_idx];
      end
      send_beat(w[0], w[1]);
    end
  endtask

  // valid stays low while the data lines carry noise
  task automatic idle_cycles(input int cycles, input bit garbage);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      valid = 1'b0;
      if (garbage) begin
        beat = {$random(seed), $random(seed)};
      end
    end
  endtask

  task automatic end_phase();
    idle_cycles(1, 1'b0);
    check_req = 1'b1;
    wait (check_ack);
    check_req = 1'b0;
    wait (!check_ack);
  endtask

  initial begin : stimulus
    seed = 48;
    error_count = 0;
    beat = '0;
    valid = 1'b0;
    cfg = '0;
    cfg.seq_sel[0] = pn9;
    cfg.seq_sel[1] = pn23;
    status_clear = 1'b0;
    check_req = 1'b0;
    for (int c = 0; c < num_chan; c++) begin
      exp_status[c] = '{oos: 1'b1, err_sticky: 1'b0, err_count: '0};
      run_len[c] = 0;
      pred_word[c] = '0;
      tx_word[c] = 32'h0000_0001;
    end
    @(negedge rst);

    // reset state while idle
    idle_cycles(8, 1'b0);
    end_phase();

    // lock on two's-complement streams
    send_stream(lock_count + 2, 1'b0, 0);
    end_phase();
    check_oos("status[0].oos", 1'b0, status[0].oos);
    check_oos("status[1].oos", 1'b0, status[1].oos);

    // three single-bit errors on channel 1
    send_stream(40, 1'b0, 12);
    end_phase();
    check_oos("status[1].oos", 1'b0, status[1].oos);

    // clear, then a zero run on channel 0
    @(posedge clk);
    #1;
    status_clear = 1'b1;
    exp_status[0].err_sticky = 1'b0;
    exp_status[0].err_count = '0;
    exp_status[1].err_sticky = 1'b0;
    exp_status[1].err_count = '0;
    @(posedge clk);
    #1;
    status_clear = 1'b0;
    end_phase();
    send_stream(lock_count, 1'b1, 0);
    end_phase();
    check_oos("status[0].oos", 1'b1, status[0].oos);

    // offset binary, both channels must lock again
    cfg.offset_binary = 1'b1;
    send_stream(40, 1'b0, 0);
    end_phase();
    check_oos("status[0].oos", 1'b0, status[0].oos);
    check_oos("status[1].oos", 1'b0, status[1].oos);

    // noise with valid low must leave status alone
    idle_cycles(50, 1'b1);
    end_phase();

    $display("run finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // ********************
  // timeout
  // ********************

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout, stimulus still running after %0d cycles", timeout_cycles);
    $display("run stopped with %0d errors", error_count);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: verification/pn_clk_gen.sv
// clock and reset source for the PN monitor testbench
// 20 ns clock, reset held high for the first 16 rising edges

`timescale 1ns/100ps

module pn_clk_gen (
  output logic clk,
  output logic rst
);

  // free running clock, half period 10 ns
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // synchronous reset, released just after the 16th edge
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule
